//--- Bender.yml
package:
  name: decode_stage

sources:
  - files:
      - common/isa_pkg.sv
      - common/pipe_pkg.sv
      - hw/decode/inst_decoder.sv
      - hw/decode/operand_bypass.sv
      - hw/decode/branch_resolve.sv
      - hw/decode/decode_stage.sv
  - target: simulation
    files:
      - sim/tb_decode_stage.sv

//--- all.f
common/isa_pkg.sv
common/pipe_pkg.sv
hw/decode/inst_decoder.sv
hw/decode/operand_bypass.sv
hw/decode/branch_resolve.sv
hw/decode/decode_stage.sv
sim/tb_decode_stage.sv

//--- common/isa_pkg.sv
package isa_pkg;

localparam int xlen       = 32;
localparam int reg_addr_w = 5;

typedef struct packed {
        logic [5:0]            op_hi;
        logic [3:0]            op_mid;
        logic [1:0]            op_lo;
        logic [4:0]            op_fn;
        logic [reg_addr_w-1:0] rk;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rd;
} r_fmt_t;

// inst[25:5], read three ways depending on the opcode.
typedef union packed {
        struct packed {
                logic [15:0]           imm16;
                logic [reg_addr_w-1:0] rj;
        } s16;
        struct packed {
                logic        sel;       // zero for lu12i and pcaddu12i.
                logic [19:0] imm20;
        } s20;
        struct packed {
                logic [3:0]            op_mid;
                logic [11:0]           imm12;
                logic [reg_addr_w-1:0] rj;
        } s12;
} imm_field_t;

typedef struct packed {
        logic [5:0]            op_hi;
        imm_field_t            up;
        logic [reg_addr_w-1:0] rd;
} i_fmt_t;

typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
} inst_t;

localparam logic [5:0] op_alu       = 6'h00;
localparam logic [5:0] op_lu12i     = 6'h05;
localparam logic [5:0] op_pcaddu12i = 6'h07;
localparam logic [5:0] op_ldst      = 6'h0a;
localparam logic [5:0] op_jirl      = 6'h13;
localparam logic [5:0] op_b         = 6'h14;
localparam logic [5:0] op_bl        = 6'h15;
localparam logic [5:0] op_beq       = 6'h16;
localparam logic [5:0] op_bne       = 6'h17;
localparam logic [5:0] op_blt       = 6'h18;
localparam logic [5:0] op_bge       = 6'h19;
localparam logic [5:0] op_bltu      = 6'h1a;
localparam logic [5:0] op_bgeu      = 6'h1b;

localparam logic [3:0] mid_3r    = 4'h0;
localparam logic [3:0] mid_shift = 4'h1;
localparam logic [3:0] mid_slti  = 4'h8;
localparam logic [3:0] mid_sltui = 4'h9;
localparam logic [3:0] mid_addi  = 4'ha;
localparam logic [3:0] mid_andi  = 4'hd;
localparam logic [3:0] mid_ori   = 4'he;
localparam logic [3:0] mid_xori  = 4'hf;

// load/store sizes, stores have bit 2 set.
localparam logic [3:0] mid_ld_b  = 4'h0;
localparam logic [3:0] mid_ld_h  = 4'h1;
localparam logic [3:0] mid_ld_w  = 4'h2;
localparam logic [3:0] mid_st_b  = 4'h4;
localparam logic [3:0] mid_st_h  = 4'h5;
localparam logic [3:0] mid_st_w  = 4'h6;
localparam logic [3:0] mid_ld_bu = 4'h8;
localparam logic [3:0] mid_ld_hu = 4'h9;

localparam logic [1:0] lo_shift = 2'h0;
localparam logic [1:0] lo_3r    = 2'h1;

localparam logic [4:0] fn_add  = 5'h00;
localparam logic [4:0] fn_sub  = 5'h02;
localparam logic [4:0] fn_slt  = 5'h04;
localparam logic [4:0] fn_sltu = 5'h05;
localparam logic [4:0] fn_nor  = 5'h08;
localparam logic [4:0] fn_and  = 5'h09;
localparam logic [4:0] fn_or   = 5'h0a;
localparam logic [4:0] fn_xor  = 5'h0b;
localparam logic [4:0] fn_sll  = 5'h0e;
localparam logic [4:0] fn_srl  = 5'h0f;
localparam logic [4:0] fn_sra  = 5'h10;
localparam logic [4:0] fn_slli = 5'h01;
localparam logic [4:0] fn_srli = 5'h09;
localparam logic [4:0] fn_srai = 5'h11;

typedef logic [11:0] alu_op_t;

// one-hot bit positions.
localparam int alu_add  = 0;
localparam int alu_sub  = 1;
localparam int alu_slt  = 2;
localparam int alu_sltu = 3;
localparam int alu_and  = 4;
localparam int alu_nor  = 5;
localparam int alu_or   = 6;
localparam int alu_xor  = 7;
localparam int alu_sll  = 8;
localparam int alu_srl  = 9;
localparam int alu_sra  = 10;
localparam int alu_lui  = 11;

typedef enum logic [3:0] {
        br_none, br_b, br_bl, br_jirl, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
} br_kind_t;

typedef enum logic [3:0] {
        mem_none, mem_ld_b, mem_ld_bu, mem_ld_h, mem_ld_hu, mem_ld_w, mem_st_b, mem_st_h, mem_st_w
} mem_kind_t;

typedef struct packed {
        alu_op_t               alu_op;
        br_kind_t              br_kind;
        mem_kind_t             mem_kind;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  src_reg_is_rd;
        logic                  gr_we;
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       imm;
} dec_ctrl_t;

endpackage

//--- common/pipe_pkg.sv
package pipe_pkg;

import isa_pkg::*;

typedef struct packed {
        logic            predict;
        logic [xlen-1:0] pc;
        inst_t           inst;
} if_id_t;

// result visible from a later stage.
typedef struct packed {
        logic                  valid;
        logic                  is_load;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
} bypass_t;

typedef struct packed {
        logic [xlen-1:0]       pc;
        inst_t                 inst;
        logic [xlen-1:0]       src1;
        logic [xlen-1:0]       src2;
        alu_op_t               alu_op;
        mem_kind_t             mem_kind;
        logic                  gr_we;
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] dest;
} id_ex_t;

endpackage

//--- hw/decode/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve import isa_pkg::*; (
        input  dec_ctrl_t       ctrl,
        input  logic [xlen-1:0] pc,
        input  inst_t           inst,
        input  logic            predict,
        input  logic            fire,
        input  logic [xlen-1:0] rj_value,
        input  logic [xlen-1:0] rkd_value,
        output logic            redirect,
        output logic [xlen-1:0] target
);

logic            eq;
logic            lt;
logic            ltu;
logic            taken;
logic [25:0]     offs26;
logic [xlen-1:0] br_offs16;
logic [xlen-1:0] br_offs26;

assign eq  = rj_value == rkd_value;
assign lt  = $signed(rj_value) < $signed(rkd_value);
assign ltu = rj_value < rkd_value;

// b/bl keep the high offset bits in the rj/rd slots.
assign offs26    = {inst.r.rj, inst.r.rd, inst.i.up.s16.imm16};
assign br_offs16 = {{14{inst.i.up.s16.imm16[15]}}, inst.i.up.s16.imm16, 2'b0};
assign br_offs26 = {{4{offs26[25]}}, offs26, 2'b0};

always_comb begin
        case (ctrl.br_kind)
        br_b, br_bl, br_jirl: taken = 1'b1;
        br_beq:  taken = eq;
        br_bne:  taken = !eq;
        br_blt:  taken = lt;
        br_bge:  taken = !lt;
        br_bltu: taken = ltu;
        br_bgeu: taken = !ltu;
        default: taken = 1'b0;
        endcase
end

always_comb begin
        case (ctrl.br_kind)
        br_jirl:     target = rj_value + br_offs16;
        br_b, br_bl: target = pc + br_offs26;
        default:     target = pc + br_offs16;
        endcase
end

// jirl target is never predicted, so it always redirects.
assign redirect = fire && ((taken != predict) || ctrl.br_kind == br_jirl);

endmodule

//--- hw/decode/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import isa_pkg::*, pipe_pkg::*; (
        input  logic                  clk,
        input  logic                  rst,
        input  logic                  flush,
        input  logic                  if_valid,
        input  if_id_t                if_bundle,
        output logic                  allowin,
        output logic [reg_addr_w-1:0] rf_raddr1,
        output logic [reg_addr_w-1:0] rf_raddr2,
        input  logic [xlen-1:0]       rf_rdata1,
        input  logic [xlen-1:0]       rf_rdata2,
        input  bypass_t               ex_byp,
        input  bypass_t               mem_byp,
        input  logic                  mem_done,
        input  logic                  ex_allowin,
        output logic                  ex_go,
        output id_ex_t                ex_bundle,
        output logic                  br_redirect,
        output logic [xlen-1:0]       br_target
);

if_id_t          id_q;
logic            valid;
logic            accept;
logic            id_ready;
logic            stall;
dec_ctrl_t       ctrl;
logic [xlen-1:0] rj_value;
logic [xlen-1:0] rkd_value;

assign accept = if_valid && allowin;

always_ff @(posedge clk) begin
        if (rst || flush) begin
                valid <= 1'b0;
        end else if (accept) begin
                valid <= 1'b1;
        end else if (ex_go) begin
                valid <= 1'b0;
        end
end

always_ff @(posedge clk) begin
        if (accept)
                id_q <= if_bundle;
end

assign id_ready = valid && !stall && !flush;
assign ex_go    = id_ready && ex_allowin;
assign allowin  = !valid || ex_go;

assign rf_raddr1 = id_q.inst.r.rj;
assign rf_raddr2 = ctrl.src_reg_is_rd ? id_q.inst.r.rd : id_q.inst.r.rk;

inst_decoder decoder_i (
        .inst (id_q.inst),
        .ctrl (ctrl)
);

operand_bypass bypass_i (
        .rj        (rf_raddr1),
        .rkd       (rf_raddr2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .ex_byp    (ex_byp),
        .mem_byp   (mem_byp),
        .mem_done  (mem_done),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
);

branch_resolve branch_i (
        .ctrl      (ctrl),
        .pc        (id_q.pc),
        .inst      (id_q.inst),
        .predict   (id_q.predict),
        .fire      (id_ready),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .redirect  (br_redirect),
        .target    (br_target)
);

always_comb begin
        ex_bundle.pc         = id_q.pc;
        ex_bundle.inst       = id_q.inst;
        ex_bundle.src1       = ctrl.src1_is_pc ? id_q.pc : rj_value;
        ex_bundle.src2       = ctrl.src2_is_imm ? ctrl.imm : rkd_value;
        ex_bundle.alu_op     = ctrl.alu_op;
        ex_bundle.mem_kind   = ctrl.mem_kind;
        ex_bundle.gr_we      = ctrl.gr_we;
        ex_bundle.store_data = rkd_value;      // rd for stores.
        ex_bundle.dest       = ctrl.dest;
end

endmodule

//--- hw/decode/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import isa_pkg::*; (
        input  inst_t     inst,
        output dec_ctrl_t ctrl
);

dec_ctrl_t       dec;
logic            known;
logic [xlen-1:0] si12;
logic [xlen-1:0] ui12;
logic [xlen-1:0] ui20;

assign si12 = {{20{inst.i.up.s12.imm12[11]}}, inst.i.up.s12.imm12};
assign ui12 = {20'b0, inst.i.up.s12.imm12};
assign ui20 = {inst.i.up.s20.imm20, 12'b0};

always_comb begin
        known           = 1'b1;
        dec             = '0;
        dec.dest        = inst.r.rd;
        dec.gr_we       = 1'b1;
        dec.src2_is_imm = 1'b1;
        dec.imm         = si12;         // shifts take ui5 from the low bits.
        case (inst.r.op_hi)
        op_alu: begin
                case (inst.r.op_mid)
                mid_3r: begin
                        dec.src2_is_imm = 1'b0;
                        known           = inst.r.op_lo == lo_3r;
                        case (inst.r.op_fn)
                        fn_add:  dec.alu_op[alu_add]  = 1'b1;
                        fn_sub:  dec.alu_op[alu_sub]  = 1'b1;
                        fn_slt:  dec.alu_op[alu_slt]  = 1'b1;
                        fn_sltu: dec.alu_op[alu_sltu] = 1'b1;
                        fn_nor:  dec.alu_op[alu_nor]  = 1'b1;
                        fn_and:  dec.alu_op[alu_and]  = 1'b1;
                        fn_or:   dec.alu_op[alu_or]   = 1'b1;
                        fn_xor:  dec.alu_op[alu_xor]  = 1'b1;
                        fn_sll:  dec.alu_op[alu_sll]  = 1'b1;
                        fn_srl:  dec.alu_op[alu_srl]  = 1'b1;
                        fn_sra:  dec.alu_op[alu_sra]  = 1'b1;
                        default: known = 1'b0;
                        endcase
                end
                mid_shift: begin
                        known = inst.r.op_lo == lo_shift;
                        case (inst.r.op_fn)
                        fn_slli: dec.alu_op[alu_sll] = 1'b1;
                        fn_srli: dec.alu_op[alu_srl] = 1'b1;
                        fn_srai: dec.alu_op[alu_sra] = 1'b1;
                        default: known = 1'b0;
                        endcase
                end
                mid_addi:  dec.alu_op[alu_add]  = 1'b1;
                mid_slti:  dec.alu_op[alu_slt]  = 1'b1;
                mid_sltui: dec.alu_op[alu_sltu] = 1'b1;
                mid_andi: begin
                        dec.alu_op[alu_and] = 1'b1;
                        dec.imm             = ui12;
                end
                mid_ori: begin
                        dec.alu_op[alu_or] = 1'b1;
                        dec.imm            = ui12;
                end
                mid_xori: begin
                        dec.alu_op[alu_xor] = 1'b1;
                        dec.imm             = ui12;
                end
                default: known = 1'b0;
                endcase
        end
        op_lu12i: begin
                known               = ~inst.i.up.s20.sel;
                dec.alu_op[alu_lui] = 1'b1;
                dec.imm             = ui20;
        end
        op_pcaddu12i: begin
                known               = ~inst.i.up.s20.sel;
                dec.alu_op[alu_add] = 1'b1;
                dec.src1_is_pc      = 1'b1;
                dec.imm             = ui20;
        end
        op_ldst: begin
                dec.alu_op[alu_add] = 1'b1;     // address = rj + si12.
                case (inst.r.op_mid)
                mid_ld_b:  dec.mem_kind = mem_ld_b;
                mid_ld_h:  dec.mem_kind = mem_ld_h;
                mid_ld_w:  dec.mem_kind = mem_ld_w;
                mid_ld_bu: dec.mem_kind = mem_ld_bu;
                mid_ld_hu: dec.mem_kind = mem_ld_hu;
                mid_st_b:  dec.mem_kind = mem_st_b;
                mid_st_h:  dec.mem_kind = mem_st_h;
                mid_st_w:  dec.mem_kind = mem_st_w;
                default:   known = 1'b0;
                endcase
                if (inst.r.op_mid[2]) begin
                        dec.gr_we         = 1'b0;
                        dec.src_reg_is_rd = 1'b1;
                end
        end
        op_jirl, op_bl: begin
                dec.alu_op[alu_add] = 1'b1;
                dec.src1_is_pc      = 1'b1;
                dec.imm             = 32'd4;    // link value pc + 4.
                if (inst.r.op_hi == op_jirl) begin
                        dec.br_kind = br_jirl;
                end else begin
                        dec.br_kind = br_bl;
                        dec.dest    = 5'd1;
                end
        end
        op_b:    dec.br_kind = br_b;
        op_beq:  dec.br_kind = br_beq;
        op_bne:  dec.br_kind = br_bne;
        op_blt:  dec.br_kind = br_blt;
        op_bge:  dec.br_kind = br_bge;
        op_bltu: dec.br_kind = br_bltu;
        op_bgeu: dec.br_kind = br_bgeu;
        default: known = 1'b0;
        endcase
        // plain branches write nothing, compares read rd.
        if (dec.br_kind != br_none && dec.br_kind != br_jirl && dec.br_kind != br_bl) begin
                dec.gr_we         = 1'b0;
                dec.src2_is_imm   = 1'b0;
                dec.src_reg_is_rd = dec.br_kind != br_b;
        end
end

assign ctrl = known ? dec : '0;

endmodule

//--- hw/decode/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass import isa_pkg::*, pipe_pkg::*; (
        input  logic [reg_addr_w-1:0] rj,
        input  logic [reg_addr_w-1:0] rkd,
        input  logic [xlen-1:0]       rf_rdata1,
        input  logic [xlen-1:0]       rf_rdata2,
        input  bypass_t               ex_byp,
        input  bypass_t               mem_byp,
        input  logic                  mem_done,
        output logic [xlen-1:0]       rj_value,
        output logic [xlen-1:0]       rkd_value,
        output logic                  stall
);

// ex beats mem beats the register file.
function automatic logic [xlen-1:0] pick(input bypass_t ex, input bypass_t mem,
                                         input logic [reg_addr_w-1:0] addr,
                                         input logic [xlen-1:0] rf_data);
        if (ex.valid && ex.addr == addr)
                return ex.data;
        if (mem.valid && mem.addr == addr)
                return mem.data;
        return rf_data;
endfunction

function automatic logic load_hit(input bypass_t byp, input logic [reg_addr_w-1:0] a1,
                                  input logic [reg_addr_w-1:0] a2);
        return byp.is_load && byp.addr != '0 && (byp.addr == a1 || byp.addr == a2);
endfunction

assign rj_value  = pick(ex_byp, mem_byp, rj, rf_rdata1);
assign rkd_value = pick(ex_byp, mem_byp, rkd, rf_rdata2);

// load data not back yet.
assign stall = load_hit(ex_byp, rj, rkd) || (load_hit(mem_byp, rj, rkd) && !mem_done);

endmodule

//--- sim/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage import isa_pkg::*, pipe_pkg::*;;

typedef struct packed {
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
        logic [xlen-1:0] store_data;
        logic [xlen-1:0] target;
        alu_op_t         alu_op;
        mem_kind_t       mem_kind;
        logic [4:0]      dest;
        logic [4:0]      raddr1;
        logic [4:0]      raddr2;
        logic            gr_we;
        logic            stall;
        logic            redirect;
} exp_t;

localparam int max_cycles = 4000;

logic clk, rst, flush, if_valid, mem_done, ex_allowin, allowin, ex_go, br_redirect;
if_id_t if_bundle, cur;
bypass_t ex_byp, mem_byp;
id_ex_t ex_bundle;
logic [reg_addr_w-1:0] rf_raddr1, rf_raddr2;
logic [xlen-1:0] rf_rdata1, rf_rdata2, br_target;
logic [xlen-1:0] rf [32];
logic [31:0] lfsr = 32'h0a6c_072b;
logic chk_en;
int cycles, checks, errors, test_errs;
string tname;

assign rf_rdata1 = rf[rf_raddr1];       // register file model.
assign rf_rdata2 = rf[rf_raddr2];

decode_stage dut_i (.*);

initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
end

always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
                $display("timeout, the run did not finish within %0d cycles", max_cycles);
                $display("Verification failed");
                $finish;
        end
end

// fibonacci lfsr, taps 32 22 2 1.
function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
                fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
                lfsr = {lfsr[30:0], fb};
                r    = {r[30:0], fb};
        end
        return r;
endfunction

task automatic check(input string what, input logic [191:0] exp, input logic [191:0] act);
        checks++;
        if (exp !== act) begin
                errors++;
                $display("Fail %s %s expected %0h actual %0h", tname, what, exp, act);
        end
endtask

function automatic logic [xlen-1:0] fwd_value(input bypass_t ex, input bypass_t mem,
                                              input logic [4:0] a);
        if (ex.valid && ex.addr == a)
                return ex.data;
        if (mem.valid && mem.addr == a)
                return mem.data;
        return rf[a];
endfunction

function automatic exp_t decode_ref(input inst_t w, input logic [xlen-1:0] pc, input logic pred,
                                    input bypass_t ex, input bypass_t mem, input logic md);
        exp_t            e;
        logic [5:0]      op;
        logic [4:0]      ra2;
        logic [xlen-1:0] va, vb, imm;
        logic            use_imm, use_pc, taken, ex_hit, mem_hit;
        op      = w[31:26];
        e       = '0;
        e.dest  = w[4:0];
        e.gr_we = 1'b1;
        ra2     = w[14:10];
        use_imm = 1'b1;
        use_pc  = 1'b0;
        imm     = {{20{w[21]}}, w[21:10]};
        if (op == op_alu && w[25:22] == mid_3r) begin
                use_imm = 1'b0;
                case (w[19:15])
                fn_add:  e.alu_op[alu_add]  = 1'b1;
                fn_sub:  e.alu_op[alu_sub]  = 1'b1;
                fn_slt:  e.alu_op[alu_slt]  = 1'b1;
                fn_sltu: e.alu_op[alu_sltu] = 1'b1;
                fn_nor:  e.alu_op[alu_nor]  = 1'b1;
                fn_and:  e.alu_op[alu_and]  = 1'b1;
                fn_or:   e.alu_op[alu_or]   = 1'b1;
                fn_xor:  e.alu_op[alu_xor]  = 1'b1;
                fn_sll:  e.alu_op[alu_sll]  = 1'b1;
                fn_srl:  e.alu_op[alu_srl]  = 1'b1;
                default: e.alu_op[alu_sra]  = 1'b1;
                endcase
        end else if (op == op_alu && w[25:22] == mid_shift) begin
                case (w[19:15])
                fn_slli: e.alu_op[alu_sll] = 1'b1;
                fn_srli: e.alu_op[alu_srl] = 1'b1;
                default: e.alu_op[alu_sra] = 1'b1;
                endcase
        end else if (op == op_alu) begin
                case (w[25:22])
                mid_addi:  e.alu_op[alu_add]  = 1'b1;
                mid_slti:  e.alu_op[alu_slt]  = 1'b1;
                mid_sltui: e.alu_op[alu_sltu] = 1'b1;
                mid_andi:  e.alu_op[alu_and]  = 1'b1;
                mid_ori:   e.alu_op[alu_or]   = 1'b1;
                default:   e.alu_op[alu_xor]  = 1'b1;
                endcase
                if (w[25:22] >= mid_andi)
                        imm = {20'b0, w[21:10]};
        end else if (op == op_lu12i || op == op_pcaddu12i) begin
                e.alu_op[op == op_lu12i ? alu_lui : alu_add] = 1'b1;
                use_pc = op == op_pcaddu12i;
                imm    = {w[24:5], 12'b0};
        end else if (op == op_ldst) begin
                e.alu_op[alu_add] = 1'b1;
                case (w[25:22])
                mid_ld_b:  e.mem_kind = mem_ld_b;
                mid_ld_h:  e.mem_kind = mem_ld_h;
                mid_ld_w:  e.mem_kind = mem_ld_w;
                mid_ld_bu: e.mem_kind = mem_ld_bu;
                mid_ld_hu: e.mem_kind = mem_ld_hu;
                mid_st_b:  e.mem_kind = mem_st_b;
                mid_st_h:  e.mem_kind = mem_st_h;
                default:   e.mem_kind = mem_st_w;
                endcase
                if (e.mem_kind inside {mem_st_b, mem_st_h, mem_st_w}) begin
                        e.gr_we = 1'b0;
                        ra2     = w[4:0];
                end
        end else if (op == op_jirl || op == op_bl) begin
                e.alu_op[alu_add] = 1'b1;
                use_pc = 1'b1;
                imm    = 32'd4;
                if (op == op_bl)
                        e.dest = 5'd1;
        end else begin
                e.gr_we = 1'b0;
                use_imm = 1'b0;
                if (op != op_b)
                        ra2 = w[4:0];
        end
        e.raddr1 = w[9:5];
        e.raddr2 = ra2;
        va = fwd_value(ex, mem, w[9:5]);
        vb = fwd_value(ex, mem, ra2);
        ex_hit  = ex.is_load && ex.addr != 0 && (ex.addr == w[9:5] || ex.addr == ra2);
        mem_hit = mem.is_load && mem.addr != 0 && (mem.addr == w[9:5] || mem.addr == ra2);
        e.stall = ex_hit || (mem_hit && !md);
        case (op)
        op_b, op_bl, op_jirl: taken = 1'b1;
        op_beq:  taken = va == vb;
        op_bne:  taken = va != vb;
        op_blt:  taken = $signed(va) < $signed(vb);
        op_bge:  taken = $signed(va) >= $signed(vb);
        op_bltu: taken = va < vb;
        op_bgeu: taken = va >= vb;
        default: taken = 1'b0;
        endcase
        if (op == op_jirl)
                e.target = va + {{14{w[25]}}, w[25:10], 2'b0};
        else if (op == op_b || op == op_bl)
                e.target = pc + {{4{w[9]}}, w[9:0], w[25:10], 2'b0};
        else
                e.target = pc + {{14{w[25]}}, w[25:10], 2'b0};
        e.redirect   = !e.stall && (taken != pred || op == op_jirl);
        e.src1       = use_pc ? pc : va;
        e.src2       = use_imm ? imm : vb;
        e.store_data = vb;
        return e;
endfunction

// compares every cycle an instruction is held.
always @(negedge clk) begin
        exp_t e;
        logic go;
        if (chk_en) begin
                e  = decode_ref(cur.inst, cur.pc, cur.predict, ex_byp, mem_byp, mem_done);
                go = !e.stall && ex_allowin && !flush;
                check("pc", cur.pc, ex_bundle.pc);
                check("inst", cur.inst, ex_bundle.inst);
                check("rf_raddr1", e.raddr1, rf_raddr1);
                check("rf_raddr2", e.raddr2, rf_raddr2);
                check("src1", e.src1, ex_bundle.src1);
                check("src2", e.src2, ex_bundle.src2);
                check("dest", e.dest, ex_bundle.dest);
                check("gr_we", e.gr_we, ex_bundle.gr_we);
                check("alu_op", e.alu_op, ex_bundle.alu_op);
                check("mem_kind", e.mem_kind, ex_bundle.mem_kind);
                check("store_data", e.store_data, ex_bundle.store_data);
                check("ex_go", go, ex_go);
                check("allowin", go, allowin);
                check("br_redirect", e.redirect && !flush, br_redirect);
                if (e.redirect)
                        check("br_target", e.target, br_target);
        end
end

task automatic load_inst(input inst_t w, input logic pred, input logic en);
        @(posedge clk);
        if_valid  <= 1'b1;
        if_bundle <= {pred, 30'(rand_bits(30)), 2'b00, w};
        @(posedge clk);
        if_valid <= 1'b0;
        cur      <= if_bundle;
        chk_en   <= en;
endtask

task automatic drain();
        do @(negedge clk); while (!ex_go);
        @(posedge clk);
        chk_en <= 1'b0;
endtask

task automatic run_inst(input inst_t w, input logic pred);
        load_inst(w, pred, 1'b1);
        drain();
endtask

task automatic start_test(input string name);
        tname     = name;
        test_errs = errors;
        for (int k = 1; k < 32; k++)
                rf[k] <= rand_bits(32);
endtask

task automatic end_test();
        $display("test %s done, %0d errors", tname, errors - test_errs);
endtask

logic [3:0] imm_mids [6] = '{mid_addi, mid_slti, mid_sltui, mid_andi, mid_ori, mid_xori};
logic [4:0] r_fns [11] = '{fn_add, fn_sub, fn_slt, fn_sltu, fn_nor, fn_and, fn_or, fn_xor,
                           fn_sll, fn_srl, fn_sra};
logic [4:0] sh_fns [3] = '{fn_slli, fn_srli, fn_srai};
logic [5:0] br_ops [9] = '{op_b, op_bl, op_jirl, op_beq, op_bne, op_blt, op_bge, op_bltu,
                           op_bgeu};
logic [3:0] ls_mids [8] = '{mid_ld_b, mid_ld_h, mid_ld_w, mid_ld_bu, mid_ld_hu, mid_st_b,
                            mid_st_h, mid_st_w};

initial begin
        inst_t w;
        logic [4:0] a;
        rst = 1'b1;
        flush = 1'b0;
        if_valid = 1'b0;
        if_bundle = '0;
        ex_byp = '0;
        mem_byp = '0;
        mem_done = 1'b1;
        ex_allowin = 1'b1;
        chk_en = 1'b0;
        foreach (rf[k])
                rf[k] = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        start_test("alu_decode");
        repeat (60) begin
                case (rand_bits(3) % 5)
                0: w = {op_alu, mid_3r, lo_3r, r_fns[rand_bits(4) % 11], 15'(rand_bits(15))};
                1: w = {op_alu, imm_mids[rand_bits(3) % 6], 22'(rand_bits(22))};
                2: w = {op_alu, mid_shift, lo_shift, sh_fns[rand_bits(2) % 3],
                        15'(rand_bits(15))};
                3: w = {op_lu12i, 1'b0, 25'(rand_bits(25))};
                default: w = {op_pcaddu12i, 1'b0, 25'(rand_bits(25))};
                endcase
                run_inst(w, 1'b0);
        end
        end_test();

        start_test("forwarding");
        repeat (60) begin
                ex_byp  <= {1'(rand_bits(1)), 1'b0, 3'b0, 2'(rand_bits(2)), rand_bits(32)};
                mem_byp <= {1'(rand_bits(1)), 1'b0, 3'b0, 2'(rand_bits(2)), rand_bits(32)};
                run_inst({op_alu, mid_3r, lo_3r, fn_add, 3'b0, 2'(rand_bits(2)), 3'b0,
                          2'(rand_bits(2)), 5'(rand_bits(5))}, 1'b0);
        end
        ex_byp  <= '0;
        mem_byp <= '0;
        end_test();

        start_test("load_use");
        repeat (20) begin
                a = 5'(rand_bits(5)) | 5'd1;
                if (rand_bits(1)) begin
                        ex_byp <= {2'b11, a, rand_bits(32)};
                end else begin
                        mem_byp  <= {2'b11, a, rand_bits(32)};
                        mem_done <= 1'b0;
                end
                load_inst({op_alu, mid_3r, lo_3r, fn_add, 5'(rand_bits(5)), a,
                           5'(rand_bits(5))}, 1'b0, 1'b1);
                repeat (2) @(posedge clk);
                ex_byp.is_load <= 1'b0;         // load data arrives.
                mem_done       <= 1'b1;
                drain();
        end
        ex_byp  <= '0;
        mem_byp <= '0;
        end_test();

        start_test("branch");
        repeat (40) begin
                w = {br_ops[rand_bits(4) % 9], 26'(rand_bits(26))};
                if (rand_bits(2) == 0)
                        w[4:0] = w[9:5];        // equal operands.
                run_inst(w, 1'(rand_bits(1)));
        end
        end_test();

        start_test("stall_flush");
        repeat (10) begin
                ex_allowin <= 1'b0;
                load_inst({op_alu, mid_addi, 22'(rand_bits(22))}, 1'b0, 1'b1);
                if_valid  <= 1'b1;              // offered while full, must wait.
                if_bundle <= {1'b0, rand_bits(32), op_alu, mid_ori, 22'(rand_bits(22))};
                repeat (3) @(negedge clk);
                @(posedge clk);
                ex_allowin <= 1'b1;
                if_valid   <= 1'b0;
                drain();
                load_inst({op_jirl, 26'(rand_bits(26))}, 1'b0, 1'b0);
                flush <= 1'b1;
                @(negedge clk);
                check("ex_go in flush", 1'b0, ex_go);
                check("redirect in flush", 1'b0, br_redirect);
                check("allowin in flush", 1'b0, allowin);
                @(posedge clk);
                flush <= 1'b0;
                @(negedge clk);
                check("allowin after flush", 1'b1, allowin);
                check("ex_go after flush", 1'b0, ex_go);
                @(posedge clk);
        end
        end_test();

        start_test("load_store");
        repeat (40)
                run_inst({op_ldst, ls_mids[rand_bits(3)], 22'(rand_bits(22))}, 1'b0);
        end_test();

        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
                $display("Verification passed");
        end else begin
                $display("Verification failed");
        end
        $finish;
end

endmodule
